//--- bench/datapath_assert.sv
`timescale 1ns/1ps
`default_nettype none

module datapath_assert import cpu_pkg::*; (
  input logic      CLK,
  input logic      nRST,
  input imem_req_t imem_req,
  input dmem_req_t dmem_req,
  input logic      dhit,
  input logic      halt
);

  int fail_count = 0;

  // No instruction fetch once halted
  a_fetch_off_when_halted: assert property (@(posedge CLK) disable iff (!nRST)
    halt |-> !imem_req.ren)
    else begin
      $error("instruction request active while halted");
      fail_count++;
    end

  a_no_read_and_write: assert property (@(posedge CLK) disable iff (!nRST)
    !(dmem_req.ren && dmem_req.wen))
    else begin
      $error("data read and write requested together");
      fail_count++;
    end

  // Pending data request holds until its hit
  a_dmem_req_stable: assert property (@(posedge CLK) disable iff (!nRST)
    ((dmem_req.ren || dmem_req.wen) && !dhit) |=> $stable(dmem_req))
    else begin
      $error("data request changed before dhit");
      fail_count++;
    end

  a_halt_sticky: assert property (@(posedge CLK) disable iff (!nRST)
    halt |=> halt)
    else begin
      $error("halt fell outside reset");
      fail_count++;
    end

endmodule

bind datapath datapath_assert u_assert (
  .CLK     (CLK),
  .nRST    (nRST),
  .imem_req(imem_req),
  .dmem_req(dmem_req),
  .dhit    (dhit),
  .halt    (halt)
);

`default_nettype wire

//--- bench/datapath_tb.sv
`timescale 1ns/1ps
`default_nettype none

module datapath_tb import cpu_pkg::*; ();

  localparam int clk_period   = 40;
  localparam int reset_cycles = 8;

  logic      CLK       = 1'b0;
  logic      nRST      = 1'b0;
  word_t     imem_load = '0;
  logic      ihit      = 1'b0;
  word_t     dmem_load = '0;
  logic      dhit      = 1'b0;
  imem_req_t imem_req;
  dmem_req_t dmem_req;
  logic      halt;

  word_t  imem [256];
  word_t  dmem [128];
  word_t  prog [$];
  string  chk_name [$];
  word_t  chk_addr [$];
  word_t  chk_exp [$];
  integer seed = 32'h4ba3_434d;
  int     iwait = 0;
  int     dwait = 0;
  int     limit;

  datapath uut (
    .CLK      (CLK),
    .nRST     (nRST),
    .imem_req (imem_req),
    .imem_load(imem_load),
    .ihit     (ihit),
    .dmem_req (dmem_req),
    .dmem_load(dmem_load),
    .dhit     (dhit),
    .halt     (halt)
  );

  initial begin
    forever #(clk_period / 2) CLK = ~CLK;
  end

  function automatic word_t rtype_word(int rs, int rt, int rd, logic [5:0] fn);
    return {op_rtype, 5'(rs), 5'(rt), 5'(rd), 5'b0, fn};
  endfunction

  function automatic word_t itype_word(logic [5:0] op, int rs, int rt, int imm);
    return {op, 5'(rs), 5'(rt), 16'(imm)};
  endfunction

  function automatic word_t jump_word(int index);
    return {op_j, 26'(index)};
  endfunction

  // Untouched data words read back as this marker
  function automatic word_t fill_word(word_t addr);
    return addr ^ 32'hbad0_0000;
  endfunction

  function automatic int draw_wait();
    return $unsigned($random(seed)) % 3;
  endfunction

  task automatic add_check(input string name, input word_t addr, input word_t exp);
    chk_name.push_back(name);
    chk_addr.push_back(addr);
    chk_exp.push_back(exp);
  endtask

  task automatic compare_word(input string name, input word_t exp, input word_t act);
    if (exp !== act) begin
      $display("MISMATCH %s expected %h actual %h", name, exp, act);
      $display("CHECKS FAILED");
      $fatal(1);
    end
  endtask

  task automatic load_program();
    // Dependent ALU chain
    prog.push_back(itype_word(op_addiu, 0, 1, 5));
    prog.push_back(itype_word(op_addiu, 1, 2, 7));
    prog.push_back(rtype_word(1, 2, 3, fn_addu));
    prog.push_back(rtype_word(3, 1, 4, fn_subu));
    prog.push_back(itype_word(op_lui, 0, 5, 'h1234));
    prog.push_back(itype_word(op_ori, 5, 5, 'h8765));
    prog.push_back(rtype_word(5, 2, 6, fn_and));
    prog.push_back(rtype_word(6, 3, 7, fn_or));
    prog.push_back(rtype_word(4, 3, 8, fn_slt));
    prog.push_back(itype_word(op_addiu, 0, 10, 'hffff));
    prog.push_back(rtype_word(10, 1, 11, fn_slt));
    prog.push_back(rtype_word(3, 4, 9, fn_slt));
    prog.push_back(itype_word(op_sw, 0, 3, 'h100));
    prog.push_back(itype_word(op_sw, 0, 4, 'h104));
    prog.push_back(itype_word(op_sw, 0, 5, 'h108));
    prog.push_back(itype_word(op_sw, 0, 6, 'h10c));
    prog.push_back(itype_word(op_sw, 0, 7, 'h110));
    prog.push_back(itype_word(op_sw, 0, 8, 'h114));
    prog.push_back(itype_word(op_sw, 0, 9, 'h118));
    prog.push_back(itype_word(op_sw, 0, 10, 'h11c));
    prog.push_back(itype_word(op_sw, 0, 11, 'h120));
    // Load then immediate use
    prog.push_back(itype_word(op_lw, 0, 12, 'h10));
    prog.push_back(rtype_word(12, 1, 13, fn_addu));
    prog.push_back(itype_word(op_sw, 0, 13, 'h124));
    // Taken BEQ at word 24 jumps to word 28
    prog.push_back(itype_word(op_beq, 2, 4, 3));
    prog.push_back(itype_word(op_sw, 0, 1, 'h128));
    prog.push_back(itype_word(op_sw, 0, 1, 'h12c));
    prog.push_back(itype_word(op_sw, 0, 1, 'h130));
    prog.push_back(itype_word(op_bne, 1, 2, 3));
    prog.push_back(itype_word(op_sw, 0, 1, 'h134));
    prog.push_back(itype_word(op_sw, 0, 1, 'h138));
    prog.push_back(itype_word(op_sw, 0, 1, 'h13c));
    // Untaken branches fall through
    prog.push_back(itype_word(op_beq, 1, 2, 1));
    prog.push_back(itype_word(op_sw, 0, 2, 'h140));
    prog.push_back(itype_word(op_bne, 2, 4, 1));
    prog.push_back(itype_word(op_sw, 0, 3, 'h144));
    prog.push_back(jump_word(40));
    prog.push_back(itype_word(op_sw, 0, 1, 'h148));
    prog.push_back(itype_word(op_sw, 0, 1, 'h14c));
    prog.push_back(itype_word(op_sw, 0, 1, 'h150));
    prog.push_back(itype_word(op_sw, 0, 7, 'h154));
    prog.push_back({op_halt, 26'd0});
    prog.push_back(itype_word(op_sw, 0, 1, 'h158));
    prog.push_back(itype_word(op_sw, 0, 1, 'h15c));
    // Past the program every word decodes as HALT
    for (int i = 0; i < 256; i++) begin
      imem[i] = (i < prog.size()) ? prog[i] : {op_halt, 26'(i)};
    end
  endtask

  task automatic load_checks();
    add_check("addu_fwd", 32'h100, 32'h0000_0011);
    add_check("subu_fwd", 32'h104, 32'h0000_000c);
    add_check("lui_ori", 32'h108, 32'h1234_8765);
    add_check("and", 32'h10c, 32'h0000_0004);
    add_check("or", 32'h110, 32'h0000_0015);
    add_check("slt_true", 32'h114, 32'h0000_0001);
    add_check("slt_false", 32'h118, 32'h0000_0000);
    add_check("addiu_neg", 32'h11c, 32'hffff_ffff);
    add_check("slt_signed", 32'h120, 32'h0000_0001);
    add_check("load_use", 32'h124, 32'h0000_1116);
    add_check("beq_skip_0", 32'h128, fill_word(32'h128));
    add_check("beq_skip_1", 32'h12c, fill_word(32'h12c));
    add_check("beq_skip_2", 32'h130, fill_word(32'h130));
    add_check("bne_skip_0", 32'h134, fill_word(32'h134));
    add_check("bne_skip_1", 32'h138, fill_word(32'h138));
    add_check("bne_skip_2", 32'h13c, fill_word(32'h13c));
    add_check("beq_fall", 32'h140, 32'h0000_000c);
    add_check("bne_fall", 32'h144, 32'h0000_0011);
    add_check("j_skip_0", 32'h148, fill_word(32'h148));
    add_check("j_skip_1", 32'h14c, fill_word(32'h14c));
    add_check("j_skip_2", 32'h150, fill_word(32'h150));
    add_check("j_target", 32'h154, 32'h0000_0015);
    add_check("after_halt_0", 32'h158, fill_word(32'h158));
    add_check("after_halt_1", 32'h15c, fill_word(32'h15c));
  endtask

  // Both memories answer together so every hit cycle advances the pipe
  always @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      ihit  <= 1'b0;
      dhit  <= 1'b0;
      iwait <= 0;
      dwait <= 0;
      // Marker words, with the load source at word 4
      for (int i = 0; i < 128; i++) begin
        dmem[i] <= fill_word(32'(i * 4));
      end
      dmem[4] <= 32'h0000_1111;
    end else if (ihit) begin
      ihit  <= 1'b0;
      dhit  <= 1'b0;
      iwait <= draw_wait();
      dwait <= draw_wait();
    end else if (imem_req.ren) begin
      if (iwait != 0) begin
        iwait <= iwait - 1;
      end
      if (dwait != 0 && (dmem_req.ren || dmem_req.wen)) begin
        dwait <= dwait - 1;
      end
      if (iwait == 0 && (!(dmem_req.ren || dmem_req.wen) || dwait == 0)) begin
        ihit      <= 1'b1;
        imem_load <= imem[imem_req.addr[9:2]];
        if (dmem_req.wen) begin
          dmem[dmem_req.addr[8:2]] <= dmem_req.store;
          dhit                     <= 1'b1;
        end else if (dmem_req.ren) begin
          dmem_load <= dmem[dmem_req.addr[8:2]];
          dhit      <= 1'b1;
        end
      end
    end
  end

  // Watchdog allows twelve cycles per program word plus reset
  initial begin
    #1;
    limit = (reset_cycles + prog.size() * 3 * 4) * clk_period;
    #(limit);
    $display("Timeout: halt never rose after %0d ns", limit);
    $display("CHECKS FAILED");
    $fatal(1);
  end

  initial begin
    wait (uut.u_assert.fail_count != 0);
    $display("A bound assertion failed on the DUT ports");
    $display("CHECKS FAILED");
    $fatal(1);
  end

  initial begin
    load_program();
    load_checks();
    repeat (reset_cycles) @(posedge CLK);
    nRST <= 1'b1;
    wait (halt === 1'b1);
    // Let a few cycles pass to see halt hold
    repeat (4) @(negedge CLK);
    for (int k = 0; k < chk_name.size(); k++) begin
      compare_word(chk_name[k], chk_exp[k], dmem[chk_addr[k][8:2]]);
    end
    compare_word("halt_held", 32'd1, {31'b0, halt});
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- project.f
src/cpu_pkg.sv
src/pipe_reg.sv
src/fetch_stage.sv
src/decode_stage.sv
src/execute_stage.sv
src/memory_stage.sv
src/hazard_unit.sv
src/forwarding_unit.sv
src/datapath.sv
bench/datapath_assert.sv
bench/datapath_tb.sv

//--- src/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0] regbits_t;

  localparam word_t pc_init = 32'h0000_0000;

  // Primary opcodes
  localparam logic [5:0] op_rtype = 6'h00;
  localparam logic [5:0] op_j     = 6'h02;
  localparam logic [5:0] op_beq   = 6'h04;
  localparam logic [5:0] op_bne   = 6'h05;
  localparam logic [5:0] op_addiu = 6'h09;
  localparam logic [5:0] op_ori   = 6'h0d;
  localparam logic [5:0] op_lui   = 6'h0f;
  localparam logic [5:0] op_lw    = 6'h23;
  localparam logic [5:0] op_sw    = 6'h2b;
  localparam logic [5:0] op_halt  = 6'h3f;

  // R-type function field
  localparam logic [5:0] fn_addu = 6'h21;
  localparam logic [5:0] fn_subu = 6'h23;
  localparam logic [5:0] fn_and  = 6'h24;
  localparam logic [5:0] fn_or   = 6'h25;
  localparam logic [5:0] fn_slt  = 6'h2a;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_slt,
    alu_lui
  } aluop_t;

  // Execute operand source
  typedef enum logic [1:0] {
    fwd_rf,
    fwd_mem,
    fwd_wb
  } fwd_sel_t;

  typedef struct packed {
    logic  ren;
    word_t addr;
  } imem_req_t;

  typedef struct packed {
    logic  ren;
    logic  wen;
    word_t addr;
    word_t store;
  } dmem_req_t;

  typedef struct packed {
    word_t instr;
    word_t pc;
    word_t npc;
  } fetch_p_t;

  typedef struct packed {
    word_t    pc;
    word_t    npc;
    regbits_t rs;
    regbits_t rt;
    regbits_t rw;
    word_t    rdat_a;
    word_t    rdat_b;
    word_t    imm;
    aluop_t   aluop;
    logic     use_imm;
    logic     dren;
    logic     dwen;
    logic     regwen;
    logic     beq;
    logic     bne;
    logic     jump;
    logic     halt;
    word_t    jump_target;
  } decode_p_t;

  typedef struct packed {
    word_t    npc;
    word_t    result;
    word_t    store;
    regbits_t rw;
    logic     dren;
    logic     dwen;
    logic     regwen;
    logic     halt;
    logic     branch_taken;
    word_t    target;
    logic     jump;
  } execute_p_t;

  typedef struct packed {
    regbits_t rw;
    logic     regwen;
    word_t    wdat;
  } memory_p_t;

endpackage

`default_nettype wire

//--- src/datapath.sv
`timescale 1ns/1ps
`default_nettype none

module datapath import cpu_pkg::*; (
  input  logic      CLK,
  input  logic      nRST,
  output imem_req_t imem_req,
  input  word_t     imem_load,
  input  logic      ihit,
  output dmem_req_t dmem_req,
  input  word_t     dmem_load,
  input  logic      dhit,
  output logic      halt
);

  fetch_p_t   ft_d;
  fetch_p_t   ft_q;
  decode_p_t  dc_d;
  decode_p_t  dc_q;
  execute_p_t ex_d;
  execute_p_t ex_q;
  memory_p_t  mm_d;
  memory_p_t  mm_q;
  imem_req_t  ft_imem_req;
  logic       mm_redirect;
  word_t      mm_target;
  fwd_sel_t   fwd_a;
  fwd_sel_t   fwd_b;
  logic [3:0] hu_flush;
  logic [3:0] hu_freeze;
  logic       wb_freeze;

  fetch_stage u_fetch (
    .CLK      (CLK),
    .nRST     (nRST),
    .freeze   (hu_freeze[3]),
    .redirect (hu_flush[3]),
    .target   (mm_target),
    .imem_load(imem_load),
    .imem_req (ft_imem_req),
    .fetch_p  (ft_d)
  );

  pipe_reg #(.payload_t(fetch_p_t)) ft_dc (
    .CLK(CLK), .nRST(nRST), .flush(hu_flush[2]), .freeze(hu_freeze[2]),
    .d(ft_d), .q(ft_q)
  );

  decode_stage u_decode (
    .CLK     (CLK),
    .nRST    (nRST),
    .fetch_p (ft_q),
    .memory_p(mm_q),
    .decode_p(dc_d)
  );

  pipe_reg #(.payload_t(decode_p_t)) dc_ex (
    .CLK(CLK), .nRST(nRST), .flush(hu_flush[1]), .freeze(hu_freeze[1]),
    .d(dc_d), .q(dc_q)
  );

  execute_stage u_execute (
    .decode_p  (dc_q),
    .fwd_a     (fwd_a),
    .fwd_b     (fwd_b),
    .mem_result(mm_d.wdat),
    .wb_result (mm_q.wdat),
    .execute_p (ex_d)
  );

  pipe_reg #(.payload_t(execute_p_t)) ex_mm (
    .CLK(CLK), .nRST(nRST), .flush(hu_flush[0]), .freeze(hu_freeze[0]),
    .d(ex_d), .q(ex_q)
  );

  memory_stage u_memory (
    .execute_p(ex_q),
    .dmem_load(dmem_load),
    .dmem_req (dmem_req),
    .redirect (mm_redirect),
    .target   (mm_target),
    .memory_p (mm_d)
  );

  // Writeback register only waits on memory
  pipe_reg #(.payload_t(memory_p_t)) mm_wb (
    .CLK(CLK), .nRST(nRST), .flush(1'b0), .freeze(wb_freeze),
    .d(mm_d), .q(mm_q)
  );

  hazard_unit u_hazard (
    .ihit       (ihit),
    .dhit       (dhit),
    .dmem_busy  (ex_q.dren || ex_q.dwen),
    .dc_ex_load (dc_q.dren),
    .dc_ex_rw   (dc_q.rw),
    .ft_dc_instr(ft_q.instr),
    .redirect   (mm_redirect),
    .flush      (hu_flush),
    .freeze     (hu_freeze),
    .wb_freeze  (wb_freeze)
  );

  forwarding_unit u_forward (
    .rs        (dc_q.rs),
    .rt        (dc_q.rt),
    .mem_rw    (ex_q.rw),
    .mem_regwen(ex_q.regwen),
    .wb_rw     (mm_q.rw),
    .wb_regwen (mm_q.regwen),
    .fwd_a     (fwd_a),
    .fwd_b     (fwd_b)
  );

  // Fetch stops while HALT sits in ex_mm, so nothing younger reaches memory
  always_comb begin
    imem_req     = ft_imem_req;
    imem_req.ren = ft_imem_req.ren && !halt && !ex_q.halt;
  end

  // Sticky until reset
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      halt <= 1'b0;
    end else if (ex_q.halt) begin
      halt <= 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- src/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage import cpu_pkg::*; (
  input  logic      CLK,
  input  logic      nRST,
  input  fetch_p_t  fetch_p,
  input  memory_p_t memory_p,
  output decode_p_t decode_p
);

  word_t      regs [32];
  logic [5:0] opcode;
  logic [5:0] funct;
  regbits_t   rs;
  regbits_t   rt;
  regbits_t   rd;
  logic [15:0] imm16;
  logic       wr_en;
  word_t      rdat_a;
  word_t      rdat_b;

  assign opcode = fetch_p.instr[31:26];
  assign rs     = fetch_p.instr[25:21];
  assign rt     = fetch_p.instr[20:16];
  assign rd     = fetch_p.instr[15:11];
  assign funct  = fetch_p.instr[5:0];
  assign imm16  = fetch_p.instr[15:0];

  // Writeback port, register zero never written
  assign wr_en = memory_p.regwen && (memory_p.rw != '0);

  // Written on the falling edge
  always_ff @(negedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[memory_p.rw] <= memory_p.wdat;
    end
  end

  // Same-cycle write bypasses to the read
  assign rdat_a = (rs == '0) ? '0 :
                  (wr_en && memory_p.rw == rs) ? memory_p.wdat : regs[rs];
  assign rdat_b = (rt == '0) ? '0 :
                  (wr_en && memory_p.rw == rt) ? memory_p.wdat : regs[rt];

  always_comb begin
    decode_p             = '0;
    decode_p.pc          = fetch_p.pc;
    decode_p.npc         = fetch_p.npc;
    decode_p.rs          = rs;
    decode_p.rt          = rt;
    decode_p.rw          = rt;
    decode_p.rdat_a      = rdat_a;
    decode_p.rdat_b      = rdat_b;
    decode_p.imm         = {{16{imm16[15]}}, imm16};
    decode_p.aluop       = alu_add;
    decode_p.jump_target = {fetch_p.npc[31:28], fetch_p.instr[25:0], 2'b00};
    case (opcode)
      op_rtype: begin
        decode_p.rw     = rd;
        decode_p.regwen = 1'b1;
        case (funct)
          fn_addu: decode_p.aluop = alu_add;
          fn_subu: decode_p.aluop = alu_sub;
          fn_and:  decode_p.aluop = alu_and;
          fn_or:   decode_p.aluop = alu_or;
          fn_slt:  decode_p.aluop = alu_slt;
          // Unsupported functions, including the all-zero bubble
          default: decode_p.regwen = 1'b0;
        endcase
      end
      op_addiu: begin
        decode_p.use_imm = 1'b1;
        decode_p.regwen  = 1'b1;
      end
      op_ori: begin
        decode_p.imm     = {16'h0000, imm16};
        decode_p.aluop   = alu_or;
        decode_p.use_imm = 1'b1;
        decode_p.regwen  = 1'b1;
      end
      op_lui: begin
        decode_p.imm     = {16'h0000, imm16};
        decode_p.aluop   = alu_lui;
        decode_p.use_imm = 1'b1;
        decode_p.regwen  = 1'b1;
      end
      op_lw: begin
        decode_p.use_imm = 1'b1;
        decode_p.dren    = 1'b1;
        decode_p.regwen  = 1'b1;
      end
      op_sw: begin
        decode_p.use_imm = 1'b1;
        decode_p.dwen    = 1'b1;
      end
      op_beq:  decode_p.beq  = 1'b1;
      op_bne:  decode_p.bne  = 1'b1;
      op_j:    decode_p.jump = 1'b1;
      op_halt: decode_p.halt = 1'b1;
      default: ;
    endcase
  end

endmodule

`default_nettype wire

//--- src/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage import cpu_pkg::*; (
  input  decode_p_t  decode_p,
  input  fwd_sel_t   fwd_a,
  input  fwd_sel_t   fwd_b,
  input  word_t      mem_result,
  input  word_t      wb_result,
  output execute_p_t execute_p
);

  word_t opa;
  word_t rdb;
  word_t opb;
  word_t result;

  // Forwarded operands
  always_comb begin
    case (fwd_a)
      fwd_mem: opa = mem_result;
      fwd_wb:  opa = wb_result;
      default: opa = decode_p.rdat_a;
    endcase
    case (fwd_b)
      fwd_mem: rdb = mem_result;
      fwd_wb:  rdb = wb_result;
      default: rdb = decode_p.rdat_b;
    endcase
  end

  assign opb = decode_p.use_imm ? decode_p.imm : rdb;

  always_comb begin
    case (decode_p.aluop)
      alu_sub: result = opa - opb;
      alu_and: result = opa & opb;
      alu_or:  result = opa | opb;
      alu_slt: result = {31'b0, $signed(opa) < $signed(opb)};
      alu_lui: result = {opb[15:0], 16'h0000};
      default: result = opa + opb;
    endcase
  end

  assign execute_p.npc    = decode_p.npc;
  assign execute_p.result = result;
  // Store data is the rt register after forwarding
  assign execute_p.store  = rdb;
  assign execute_p.rw     = decode_p.rw;
  assign execute_p.dren   = decode_p.dren;
  assign execute_p.dwen   = decode_p.dwen;
  assign execute_p.regwen = decode_p.regwen;
  assign execute_p.halt   = decode_p.halt;
  assign execute_p.jump   = decode_p.jump;

  assign execute_p.branch_taken = (decode_p.beq && (opa == rdb)) ||
                                  (decode_p.bne && (opa != rdb));
  assign execute_p.target = decode_p.jump ? decode_p.jump_target :
                            decode_p.npc + {decode_p.imm[29:0], 2'b00};

endmodule

`default_nettype wire

//--- src/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_stage import cpu_pkg::*; (
  input  logic      CLK,
  input  logic      nRST,
  input  logic      freeze,
  input  logic      redirect,
  input  word_t     target,
  input  word_t     imem_load,
  output imem_req_t imem_req,
  output fetch_p_t  fetch_p
);

  word_t pc;
  word_t npc;

  assign npc = pc + 32'd4;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      pc <= pc_init;
    end else if (!freeze) begin
      // Taken branch or jump from the memory stage
      pc <= redirect ? target : npc;
    end
  end

  // Request is always on here, the top level masks it after halt
  assign imem_req.ren  = 1'b1;
  assign imem_req.addr = pc;

  assign fetch_p.instr = imem_load;
  assign fetch_p.pc    = pc;
  assign fetch_p.npc   = npc;

endmodule

`default_nettype wire

//--- src/forwarding_unit.sv
`timescale 1ns/1ps
`default_nettype none

module forwarding_unit import cpu_pkg::*; (
  input  regbits_t rs,
  input  regbits_t rt,
  input  regbits_t mem_rw,
  input  logic     mem_regwen,
  input  regbits_t wb_rw,
  input  logic     wb_regwen,
  output fwd_sel_t fwd_a,
  output fwd_sel_t fwd_b
);

  logic mem_valid;
  logic wb_valid;

  assign mem_valid = mem_regwen && (mem_rw != '0);
  assign wb_valid  = wb_regwen && (wb_rw != '0);

  // Younger producer in the memory stage wins
  always_comb begin
    fwd_a = fwd_rf;
    fwd_b = fwd_rf;
    if (mem_valid && mem_rw == rs) begin
      fwd_a = fwd_mem;
    end else if (wb_valid && wb_rw == rs) begin
      fwd_a = fwd_wb;
    end
    if (mem_valid && mem_rw == rt) begin
      fwd_b = fwd_mem;
    end else if (wb_valid && wb_rw == rt) begin
      fwd_b = fwd_wb;
    end
  end

endmodule

`default_nettype wire

//--- src/hazard_unit.sv
`timescale 1ns/1ps
`default_nettype none

module hazard_unit import cpu_pkg::*; (
  input  logic       ihit,
  input  logic       dhit,
  input  logic       dmem_busy,
  input  logic       dc_ex_load,
  input  regbits_t   dc_ex_rw,
  input  word_t      ft_dc_instr,
  input  logic       redirect,
  output logic [3:0] flush,
  output logic [3:0] freeze,
  output logic       wb_freeze
);

  logic mem_wait;
  logic load_use;

  // Any outstanding memory access holds the whole pipe
  assign mem_wait = !ihit || (dmem_busy && !dhit);

  assign load_use = dc_ex_load && (dc_ex_rw != '0) &&
                    ((dc_ex_rw == ft_dc_instr[25:21]) ||
                     (dc_ex_rw == ft_dc_instr[20:16]));

  // Bit 3 PC, 2 ft_dc, 1 dc_ex, 0 ex_mm
  always_comb begin
    flush  = 4'b0000;
    freeze = 4'b0000;
    if (mem_wait) begin
      freeze = 4'b1111;
    end else if (redirect) begin
      // Flush of the PC means load the redirect target
      flush = 4'b1111;
    end else if (load_use) begin
      freeze = 4'b1100;
      flush  = 4'b0010;
    end
  end

  assign wb_freeze = mem_wait;

endmodule

`default_nettype wire

//--- src/memory_stage.sv
`timescale 1ns/1ps
`default_nettype none

module memory_stage import cpu_pkg::*; (
  input  execute_p_t execute_p,
  input  word_t      dmem_load,
  output dmem_req_t  dmem_req,
  output logic       redirect,
  output word_t      target,
  output memory_p_t  memory_p
);

  // ALU result is the data address
  assign dmem_req.ren   = execute_p.dren;
  assign dmem_req.wen   = execute_p.dwen;
  assign dmem_req.addr  = execute_p.result;
  assign dmem_req.store = execute_p.store;

  // Branches resolve here, predicted not taken
  assign redirect = execute_p.branch_taken || execute_p.jump;
  assign target   = execute_p.target;

  // Writeback select
  assign memory_p.rw     = execute_p.rw;
  assign memory_p.regwen = execute_p.regwen;
  assign memory_p.wdat   = execute_p.dren ? dmem_load : execute_p.result;

endmodule

`default_nettype wire

//--- src/pipe_reg.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     CLK,
  input  logic     nRST,
  input  logic     flush,
  input  logic     freeze,
  input  payload_t d,
  output payload_t q
);

  // Freeze has priority over flush, a flush inserts an all-zero bubble
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      q <= '0;
    end else if (!freeze) begin
      if (flush) begin
        q <= '0;
      end else begin
        q <= d;
      end
    end
  end

endmodule

`default_nettype wire
